// ==== hw/dsp_settings.svh ====
/* servo routing hub settings
   widths, counts and register offsets shared by the hub blocks */
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

`define DSP_SAMPLE_W   14  // adc/dac sample width
`define DSP_SLOTS      8   // processing slots
`define DSP_SEL_W      4   // source code width
`define DSP_SOURCES    16  // 2**DSP_SEL_W entries in source table
`define DSP_CONSUMERS  12  // slots, two scopes, two pwm
`define DSP_DIRECTS    10  // slots plus both asg channels

// system bus
`define DSP_BUS_W      32
`define DSP_IDX_LSB    16  // index field starts here, offset below

// register offsets within the hub block
`define DSP_OFS_INSEL  16'h0000
`define DSP_OFS_OUTSEL 16'h0004
`define DSP_OFS_SAT    16'h0008
`define DSP_OFS_SYNC   16'h000C
`define DSP_OFS_PROBE  16'h0010

`endif

// ==== hw/dsp_pkg.sv ====
/* servo routing hub types
   sample, select, destination and sum types with source and consumer codes */
`include "dsp_settings.svh"

package dsp_pkg;

   typedef logic signed [`DSP_SAMPLE_W-1:0] sample_t;
   typedef logic        [`DSP_SEL_W-1:0]    sel_t;
   typedef logic        [1:0]               dest_t;     // bit 0 dac a, bit 1 dac b
   // room for all sources summed without wrap
   typedef logic signed [`DSP_SAMPLE_W+`DSP_SEL_W-1:0] sum_t;

   // destination bit positions, also used as channel index in the tree
   localparam int DEST_A = 0;
   localparam int DEST_B = 1;

   // source codes, slots occupy 0..DSP_SLOTS-1
   localparam sel_t SRC_ASG_A   = sel_t'(8);
   localparam sel_t SRC_ASG_B   = sel_t'(9);
   localparam sel_t SRC_ADC_A   = sel_t'(10);
   localparam sel_t SRC_ADC_B   = sel_t'(11);
   localparam sel_t SRC_DAC_A   = sel_t'(12);   // registered dac outputs fed back
   localparam sel_t SRC_DAC_B   = sel_t'(13);
   localparam sel_t SRC_SLOT7_Q = sel_t'(14);   // second output of slot 7
   localparam sel_t SRC_NONE    = sel_t'(15);   // routes zero

   // consumer indices, slots occupy 0..DSP_SLOTS-1
   localparam int CON_SCOPE_A = 8;
   localparam int CON_SCOPE_B = 9;
   localparam int CON_PWM_A   = 10;
   localparam int CON_PWM_B   = 11;

endpackage

// ==== hw/dsp_route_regs.sv ====
/* routing hub register file
   select, destination and sync registers with bus decode and read mux */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_route_regs (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   // system bus
   input  logic [`DSP_BUS_W-1:0] sys_addr_i,
   input  logic [`DSP_BUS_W-1:0] sys_wdata_i,
   input  logic                  sys_wen_i,
   input  logic                  sys_ren_i,
   output logic [`DSP_BUS_W-1:0] sys_rdata_o,
   output logic                  sys_ack_o,
   output logic                  sys_err_o,
   // status for readback
   input  dsp_pkg::sample_t      sources_i [`DSP_SOURCES],
   input  logic [1:0]            sat_i,        // {dac b, dac a}
   // routing control
   output dsp_pkg::sel_t         in_sel_o  [`DSP_CONSUMERS],
   output dsp_pkg::dest_t        dest_o    [`DSP_DIRECTS],
   output logic [`DSP_SLOTS-1:0] sync_o
);
   import dsp_pkg::*;

   logic [`DSP_IDX_LSB-1:0] ofs;       // register offset
   logic [`DSP_SEL_W-1:0]   idx;       // consumer or source index
   logic                    known;     // offset decodes to a hub register
   logic                    strobe;
   logic [`DSP_BUS_W-1:0]   rdata_d;

   sel_t                  in_sel_q [`DSP_CONSUMERS];
   dest_t                 dest_q   [`DSP_DIRECTS];
   logic [`DSP_SLOTS-1:0] sync_q;

   assign ofs    = sys_addr_i[`DSP_IDX_LSB-1:0];
   assign idx    = sys_addr_i[`DSP_IDX_LSB +: `DSP_SEL_W];
   assign strobe = sys_wen_i | sys_ren_i;

   // register writes
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int c = 0; c < `DSP_SLOTS; c++) begin
            in_sel_q[c] <= SRC_ADC_A;            // slots follow adc a out of reset
         end
         in_sel_q[CON_SCOPE_A] <= SRC_ADC_A;
         in_sel_q[CON_SCOPE_B] <= SRC_ADC_B;
         in_sel_q[CON_PWM_A]   <= SRC_NONE;      // pwm quiet until routed
         in_sel_q[CON_PWM_B]   <= SRC_NONE;
         for (int n = 0; n < `DSP_DIRECTS; n++) begin
            dest_q[n] <= '0;                     // nothing on the dacs
         end
         sync_q <= '1;                           // all slots running
      end else if (sys_wen_i) begin
         if (ofs == `DSP_OFS_INSEL && idx < `DSP_CONSUMERS) begin
            in_sel_q[idx] <= sys_wdata_i[`DSP_SEL_W-1:0];
         end
         if (ofs == `DSP_OFS_OUTSEL && idx < `DSP_DIRECTS) begin
            dest_q[idx] <= sys_wdata_i[1:0];
         end
         if (ofs == `DSP_OFS_SYNC) begin
            sync_q <= sys_wdata_i[`DSP_SLOTS-1:0]; // index ignored here
         end
      end
   end

   // read mux, fields zero extended
   always_comb begin
      rdata_d = '0;
      known   = 1'b1;
      case (ofs)
         `DSP_OFS_INSEL: begin
            if (idx < `DSP_CONSUMERS) rdata_d[`DSP_SEL_W-1:0] = in_sel_q[idx];
         end
         `DSP_OFS_OUTSEL: begin
            if (idx < `DSP_DIRECTS) rdata_d[1:0] = dest_q[idx];
         end
         `DSP_OFS_SAT:   rdata_d[1:0]            = sat_i;
         `DSP_OFS_SYNC:  rdata_d[`DSP_SLOTS-1:0] = sync_q;
         `DSP_OFS_PROBE: rdata_d[`DSP_SAMPLE_W-1:0] = sources_i[idx]; // live source value
         default:        known = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= strobe & known;   // one cycle, unknown offsets stay silent
      end
   end

   always_ff @(posedge clk_i) begin
      sys_rdata_o <= rdata_d;           // valid alongside ack
   end

   assign sys_err_o = 1'b0;
   assign in_sel_o  = in_sel_q;
   assign dest_o    = dest_q;
   assign sync_o    = sync_q;

   // ack only ever answers a strobe from the cycle before
   ack_follows_strobe: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      $rose(sys_ack_o) |-> $past(strobe)
   ) else $error("ack rose without a bus strobe");

endmodule

// ==== hw/dsp_signal_router.sv ====
/* routing matrix
   each consumer picks one entry of the source table, code 15 gives zero */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_signal_router (
   input  dsp_pkg::sample_t sources_i    [`DSP_SOURCES],
   input  dsp_pkg::sel_t    in_sel_i     [`DSP_CONSUMERS],
   output dsp_pkg::sample_t slot_input_o [`DSP_SLOTS],
   output dsp_pkg::sample_t scope_a_o,
   output dsp_pkg::sample_t scope_b_o,
   output dsp_pkg::sample_t pwm_a_o,
   output dsp_pkg::sample_t pwm_b_o
);
   import dsp_pkg::*;

   sample_t con_sig [`DSP_CONSUMERS];   // selected signal per consumer

   // one mux per consumer, no register in the path
   for (genvar c = 0; c < `DSP_CONSUMERS; c++) begin : g_con
      assign con_sig[c] = sources_i[in_sel_i[c]];
   end

   for (genvar s = 0; s < `DSP_SLOTS; s++) begin : g_slot
      assign slot_input_o[s] = con_sig[s];
   end

   assign scope_a_o = con_sig[CON_SCOPE_A];
   assign scope_b_o = con_sig[CON_SCOPE_B];
   assign pwm_a_o   = con_sig[CON_PWM_A];  // pwm drivers expect hard zero when off
   assign pwm_b_o   = con_sig[CON_PWM_B];

   // unrouted pwm reads the table's zero entry
   always_comb begin
      assert (in_sel_i[CON_PWM_A] != SRC_NONE || pwm_a_o == '0)
         else $error("pwm a not zero while unrouted");
      assert (in_sel_i[CON_PWM_B] != SRC_NONE || pwm_b_o == '0)
         else $error("pwm b not zero while unrouted");
   end

endmodule

// ==== hw/dsp_sum_tree.sv ====
/* two-channel adder tree
   gated direct outputs summed in a five stage pipeline per dac channel */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_sum_tree (
   input  logic             clk_i,
   input  logic             rstn_i,
   input  dsp_pkg::sample_t directs_i [`DSP_DIRECTS],
   input  dsp_pkg::dest_t   dest_i    [`DSP_DIRECTS],
   output dsp_pkg::sum_t    sum_a_o,
   output dsp_pkg::sum_t    sum_b_o
);
   import dsp_pkg::*;

   localparam int LEAVES = 8;   // pair sums entering the tree, 8 -> 4 -> 2 -> 1

   sum_t gated  [2][2*LEAVES];  // sign extended and masked by destination
   sum_t pair_q [2][LEAVES];    // stage 1
   sum_t lvl1_q [2][LEAVES/2];  // stage 2
   sum_t lvl2_q [2][LEAVES/4];  // stage 3
   sum_t lvl3_q [2];            // stage 4
   sum_t out_q  [2];            // stage 5

   // destination gating, unused leaves stay zero
   always_comb begin
      for (int ch = 0; ch < 2; ch++) begin
         for (int n = 0; n < 2*LEAVES; n++) begin
            gated[ch][n] = '0;
         end
         for (int n = 0; n < `DSP_DIRECTS; n++) begin
            if (dest_i[n][ch]) gated[ch][n] = sum_t'(directs_i[n]);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int ch = 0; ch < 2; ch++) begin
            for (int p = 0; p < LEAVES; p++) pair_q[ch][p] <= '0;
            for (int k = 0; k < LEAVES/2; k++) lvl1_q[ch][k] <= '0;
            for (int k = 0; k < LEAVES/4; k++) lvl2_q[ch][k] <= '0;
            lvl3_q[ch] <= '0;
            out_q[ch]  <= '0;   // dacs sit at zero after reset
         end
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            // at most two operands per adder
            for (int p = 0; p < LEAVES; p++) begin
               pair_q[ch][p] <= gated[ch][2*p] + gated[ch][2*p+1];
            end
            for (int k = 0; k < LEAVES/2; k++) begin
               lvl1_q[ch][k] <= pair_q[ch][2*k] + pair_q[ch][2*k+1];
            end
            for (int k = 0; k < LEAVES/4; k++) begin
               lvl2_q[ch][k] <= lvl1_q[ch][2*k] + lvl1_q[ch][2*k+1];
            end
            lvl3_q[ch] <= lvl2_q[ch][0] + lvl2_q[ch][1];
            out_q[ch]  <= lvl3_q[ch];   // extra register for slack into saturation
         end
      end
   end

   assign sum_a_o = out_q[DEST_A];
   assign sum_b_o = out_q[DEST_B];

endmodule

// ==== hw/dsp_dac_saturate.sv ====
/* dac saturation
   clips a wide signed sum into the sample range and flags the overflow */
`timescale 1ns/1ps

module dsp_dac_saturate #(
   parameter int IN_W = $bits(dsp_pkg::sum_t)   // must be at least the sample width
) (
   input  logic signed [IN_W-1:0] sum_i,
   output dsp_pkg::sample_t       dac_o,
   output logic                   over_o
);
   import dsp_pkg::*;

   localparam int OUT_W = $bits(sample_t);
   localparam sample_t MAX_VAL = sample_t'({1'b0, {(OUT_W-1){1'b1}}});   // +8191
   localparam sample_t MIN_VAL = sample_t'({1'b1, {(OUT_W-1){1'b0}}});   // -8192

   logic [IN_W-OUT_W:0] top_bits;   // everything from the output msb upward

   assign top_bits = sum_i[IN_W-1:OUT_W-1];
   // in range only if the top bits are a pure sign extension
   assign over_o = !((&top_bits) || !(|top_bits));
   assign dac_o  = !over_o ? sample_t'(sum_i[OUT_W-1:0]) :
                   (sum_i[IN_W-1] ? MIN_VAL : MAX_VAL);

   // without the flag the value must pass through untouched
   always_comb begin
      assert (over_o || IN_W'(dac_o) == sum_i)
         else $error("saturation changed an in-range value");
   end

endmodule

// ==== hw/dsp_hub.sv ====
/* servo routing hub top
   source table, routing matrix, dac adder tree, saturation and register access */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_hub (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   // converters and generators
   input  dsp_pkg::sample_t      adc_a_i,
   input  dsp_pkg::sample_t      adc_b_i,
   input  dsp_pkg::sample_t      asg_a_i,
   input  dsp_pkg::sample_t      asg_b_i,
   output dsp_pkg::sample_t      dac_a_o,
   output dsp_pkg::sample_t      dac_b_o,
   // processing slots
   input  dsp_pkg::sample_t      slot_direct_i [`DSP_SLOTS],
   input  dsp_pkg::sample_t      slot_signal_i [`DSP_SLOTS],
   input  dsp_pkg::sample_t      slot7_q_i,
   output dsp_pkg::sample_t      slot_input_o  [`DSP_SLOTS],
   output logic [`DSP_SLOTS-1:0] sync_o,
   // scope and pwm consumers
   output dsp_pkg::sample_t      scope_a_o,
   output dsp_pkg::sample_t      scope_b_o,
   output dsp_pkg::sample_t      pwm_a_o,
   output dsp_pkg::sample_t      pwm_b_o,
   // system bus
   input  logic [`DSP_BUS_W-1:0] sys_addr_i,
   input  logic [`DSP_BUS_W-1:0] sys_wdata_i,
   input  logic                  sys_wen_i,
   input  logic                  sys_ren_i,
   output logic [`DSP_BUS_W-1:0] sys_rdata_o,
   output logic                  sys_ack_o,
   output logic                  sys_err_o
);
   import dsp_pkg::*;

   sample_t sources [`DSP_SOURCES];   // routed signal of every source code
   sample_t directs [`DSP_DIRECTS];   // outputs eligible for the dacs
   sel_t    in_sel  [`DSP_CONSUMERS];
   dest_t   dest    [`DSP_DIRECTS];
   sum_t    sum_a;
   sum_t    sum_b;
   logic    over_a;
   logic    over_b;

   for (genvar s = 0; s < `DSP_SLOTS; s++) begin : g_tab
      assign sources[s] = slot_signal_i[s];
      assign directs[s] = slot_direct_i[s];
   end
   assign sources[SRC_ASG_A]   = asg_a_i;
   assign sources[SRC_ASG_B]   = asg_b_i;
   assign sources[SRC_ADC_A]   = adc_a_i;
   assign sources[SRC_ADC_B]   = adc_b_i;
   assign sources[SRC_DAC_A]   = dac_a_o;    // loop back through the tree registers
   assign sources[SRC_DAC_B]   = dac_b_o;
   assign sources[SRC_SLOT7_Q] = slot7_q_i;
   assign sources[SRC_NONE]    = '0;
   assign directs[SRC_ASG_A]   = asg_a_i;    // asg codes double as direct indices
   assign directs[SRC_ASG_B]   = asg_b_i;

   dsp_route_regs i_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .sys_err_o   (sys_err_o),
      .sources_i   (sources),
      .sat_i       ({over_b, over_a}),
      .in_sel_o    (in_sel),
      .dest_o      (dest),
      .sync_o      (sync_o)
   );

   dsp_signal_router i_router (
      .sources_i    (sources),
      .in_sel_i     (in_sel),
      .slot_input_o (slot_input_o),
      .scope_a_o    (scope_a_o),
      .scope_b_o    (scope_b_o),
      .pwm_a_o      (pwm_a_o),
      .pwm_b_o      (pwm_b_o)
   );

   dsp_sum_tree i_sum (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .directs_i (directs),
      .dest_i    (dest),
      .sum_a_o   (sum_a),
      .sum_b_o   (sum_b)
   );

   dsp_dac_saturate #(.IN_W($bits(sum_t))) i_sat_a (
      .sum_i  (sum_a),
      .dac_o  (dac_a_o),
      .over_o (over_a)
   );

   dsp_dac_saturate #(.IN_W($bits(sum_t))) i_sat_b (
      .sum_i  (sum_b),
      .dac_o  (dac_b_o),
      .over_o (over_b)
   );

endmodule

// ==== bench/dsp_hub_clkgen.sv ====
/* testbench clock and reset
   100 ns clock, active low reset held for the first 16 rising edges */
`timescale 1ns/1ps

module dsp_hub_clkgen (
   output logic clk_o,
   output logic rstn_o
);
   localparam int RST_CYCLES = 16;

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;   // half period
   end

   initial begin
      rstn_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rstn_o <= 1'b1;                // released on an edge like the other inputs
   end

endmodule

// ==== bench/dsp_hub_tb.sv ====
/* routing hub testbench
   random routing, adder tree, saturation and bus checks with error counts */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_hub_tb;
   import dsp_pkg::*;

   localparam int ACK_TIMEOUT = 8;    // cycles allowed for sys_ack_o
   localparam int RST_TIMEOUT = 40;
   localparam int TREE_LAT    = 5;    // direct input or destination to dac

   // nets carry the dut port names, instance connects by name
   logic                  clk_i;
   logic                  rstn_i;
   sample_t               adc_a_i, adc_b_i, asg_a_i, asg_b_i, slot7_q_i;
   sample_t               slot_direct_i [`DSP_SLOTS];
   sample_t               slot_signal_i [`DSP_SLOTS];
   sample_t               slot_input_o  [`DSP_SLOTS];
   sample_t               dac_a_o, dac_b_o, scope_a_o, scope_b_o, pwm_a_o, pwm_b_o;
   logic [`DSP_SLOTS-1:0] sync_o;
   logic [`DSP_BUS_W-1:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
   logic                  sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

   dest_t       dest_m [`DSP_DIRECTS];   // destinations as written
   logic [31:0] rng      = 32'd79;       // xorshift state
   int          checks   = 0;
   int          errors   = 0;
   int          timeouts = 0;

   dsp_hub_clkgen i_clkgen (
      .clk_o  (clk_i),
      .rstn_o (rstn_i)
   );

   dsp_hub i_dsp_hub (.*);

   function automatic logic [31:0] rand_word();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // -500..500, ten of them never clip
   function automatic sample_t small_sample();
      return sample_t'(int'(rand_word() % 32'd1001) - 500);
   endfunction

   function automatic sample_t direct_value(input int n);
      if (n < `DSP_SLOTS) return slot_direct_i[n];
      return (n == int'(SRC_ASG_A)) ? asg_a_i : asg_b_i;
   endfunction

   // settled dac value from the written destinations, clipped to 14 bits
   function automatic sample_t expected_dac(input int ch);
      int sum;
      sum = 0;
      for (int n = 0; n < `DSP_DIRECTS; n++) begin
         if (dest_m[n][ch]) sum += direct_value(n);
      end
      if (sum > 8191) sum = 8191;
      if (sum < -8192) sum = -8192;
      return sample_t'(sum);
   endfunction

   function automatic sample_t source_value(input int code);
      if (code < `DSP_SLOTS) return slot_signal_i[code];
      case (code)
         SRC_ASG_A:   return asg_a_i;
         SRC_ASG_B:   return asg_b_i;
         SRC_ADC_A:   return adc_a_i;
         SRC_ADC_B:   return adc_b_i;
         SRC_DAC_A:   return expected_dac(0);   // fed back dac, settled
         SRC_DAC_B:   return expected_dac(1);
         SRC_SLOT7_Q: return slot7_q_i;
         default:     return '0;                // SRC_NONE
      endcase
   endfunction

   function automatic sample_t consumer_out(input int c);
      if (c < `DSP_SLOTS) return slot_input_o[c];
      case (c)
         CON_SCOPE_A: return scope_a_o;
         CON_SCOPE_B: return scope_b_o;
         CON_PWM_A:   return pwm_a_o;
         default:     return pwm_b_o;
      endcase
   endfunction

   function automatic string consumer_name(input int c);
      if (c < `DSP_SLOTS) return $sformatf("slot_input_o[%0d]", c);
      case (c)
         CON_SCOPE_A: return "scope_a_o";
         CON_SCOPE_B: return "scope_b_o";
         CON_PWM_A:   return "pwm_a_o";
         default:     return "pwm_b_o";
      endcase
   endfunction

   task automatic expect_hex(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("ERROR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // one strobe cycle, then ack is due on the next edge or never for unmapped offsets
   task automatic access_reg(input logic wr, input logic [15:0] ofs, input int idx,
                             input logic [31:0] wdata, input logic known,
                             output logic [31:0] rdata);
      int waited;
      @(posedge clk_i);
      sys_addr_i  <= {12'd0, 4'(idx), ofs};
      sys_wdata_i <= wdata;
      sys_wen_i   <= wr;
      sys_ren_i   <= !wr;
      @(negedge clk_i);
      expect_hex("sys_ack_o", 32'd0, 32'(sys_ack_o));   // no same cycle answer
      @(posedge clk_i);
      sys_wen_i <= 1'b0;
      sys_ren_i <= 1'b0;
      waited = 0;
      do begin
         @(negedge clk_i);
         waited++;
      end while (!sys_ack_o && waited < ACK_TIMEOUT);
      rdata = sys_rdata_o;
      expect_hex("sys_err_o", 32'd0, 32'(sys_err_o));
      if (known && !sys_ack_o) begin
         timeouts++;
         $display("timeout: no ack within %0d cycles at offset %h", ACK_TIMEOUT, ofs);
      end else begin
         assert (!known || waited == 1) else begin
            errors++;
            $display("ack came %0d cycles after the strobe at offset %h, not one", waited, ofs);
         end
         assert (known || !sys_ack_o) else begin
            errors++;
            $display("ack answered the unmapped offset %h", ofs);
         end
      end
   endtask

   // old sums for four cycles after the change edge, new sums on the fifth
   task automatic latency_check(input sample_t old_a, old_b, new_a, new_b);
      for (int k = 1; k <= TREE_LAT; k++) begin
         @(negedge clk_i);
         expect_hex("dac_a_o", (k < TREE_LAT) ? old_a : new_a, dac_a_o);
         expect_hex("dac_b_o", (k < TREE_LAT) ? old_b : new_b, dac_b_o);
      end
   endtask

   task automatic randomize_signals();
      @(posedge clk_i);
      for (int s = 0; s < `DSP_SLOTS; s++) slot_signal_i[s] <= sample_t'(rand_word());
      adc_a_i   <= sample_t'(rand_word());
      adc_b_i   <= sample_t'(rand_word());
      slot7_q_i <= sample_t'(rand_word());
   endtask

   task automatic randomize_directs();
      @(posedge clk_i);
      for (int s = 0; s < `DSP_SLOTS; s++) slot_direct_i[s] <= small_sample();
      asg_a_i <= small_sample();
      asg_b_i <= small_sample();
   endtask

   initial begin
      logic [31:0] rd;
      sample_t     old_a;
      sample_t     old_b;
      int          c;
      int          code;
      int          j;
      adc_a_i     <= '0;
      adc_b_i     <= '0;
      asg_a_i     <= '0;
      asg_b_i     <= '0;
      slot7_q_i   <= '0;
      sys_addr_i  <= '0;
      sys_wdata_i <= '0;
      sys_wen_i   <= 1'b0;
      sys_ren_i   <= 1'b0;
      for (int s = 0; s < `DSP_SLOTS; s++) begin
         slot_direct_i[s] <= '0;
         slot_signal_i[s] <= '0;
      end
      for (int n = 0; n < `DSP_DIRECTS; n++) dest_m[n] = '0;
      for (int k = 0; k < RST_TIMEOUT && !rstn_i; k++) @(posedge clk_i);
      if (!rstn_i) begin
         timeouts++;
         $display("timeout: reset was not released within %0d cycles", RST_TIMEOUT);
      end

      // reset defaults
      randomize_signals();
      @(negedge clk_i);
      expect_hex("scope_a_o", adc_a_i, scope_a_o);
      expect_hex("scope_b_o", adc_b_i, scope_b_o);
      for (int s = 0; s < `DSP_SLOTS; s++) expect_hex(consumer_name(s), adc_a_i, slot_input_o[s]);
      expect_hex("pwm_a_o", 32'd0, pwm_a_o);
      expect_hex("pwm_b_o", 32'd0, pwm_b_o);
      expect_hex("dac_a_o", 32'd0, dac_a_o);
      expect_hex("dac_b_o", 32'd0, dac_b_o);
      access_reg(1'b0, `DSP_OFS_SYNC, 0, '0, 1'b1, rd);
      expect_hex("sys_rdata_o", 32'hFF, rd);

      // routing, first two passes park the pwm channels on SRC_NONE
      for (int i = 0; i < 40; i++) begin
         c    = int'(rand_word() % `DSP_CONSUMERS);
         code = int'(rand_word() % `DSP_SOURCES);
         if (i < 2) begin
            c    = CON_PWM_A + i;
            code = SRC_NONE;
         end
         randomize_signals();
         access_reg(1'b1, `DSP_OFS_INSEL, c, 32'(code), 1'b1, rd);
         expect_hex(consumer_name(c), source_value(code), consumer_out(c));
         access_reg(1'b0, `DSP_OFS_INSEL, c, '0, 1'b1, rd);
         expect_hex("sys_rdata_o", 32'(code), rd);
      end

      // summing, then one destination flip and one direct change per round
      for (int r = 0; r < 3; r++) begin
         randomize_directs();
         for (int n = 0; n < `DSP_DIRECTS; n++) begin
            dest_m[n] = dest_t'(rand_word());
            access_reg(1'b1, `DSP_OFS_OUTSEL, n, 32'(dest_m[n]), 1'b1, rd);
         end
         repeat (TREE_LAT + 1) @(negedge clk_i);
         old_a = expected_dac(0);
         old_b = expected_dac(1);
         j = int'(rand_word() % `DSP_DIRECTS);
         dest_m[j] = dest_m[j] ^ 2'b11;
         access_reg(1'b1, `DSP_OFS_OUTSEL, j, 32'(dest_m[j]), 1'b1, rd);
         latency_check(old_a, old_b, expected_dac(0), expected_dac(1));
         old_a = expected_dac(0);
         old_b = expected_dac(1);
         @(posedge clk_i);
         slot_direct_i[j % `DSP_SLOTS] <= small_sample();
         @(negedge clk_i);
         latency_check(old_a, old_b, expected_dac(0), expected_dac(1));
      end

      // saturation, +40000 on dac a while dac b holds -8000 in range
      @(posedge clk_i);
      for (int s = 0; s < `DSP_SLOTS; s++) slot_direct_i[s] <= (s < 5) ? 14'sd8000 : -14'sd8000;
      asg_a_i <= -14'sd8000;
      asg_b_i <= -14'sd8000;
      for (int n = 0; n < `DSP_DIRECTS; n++) begin
         dest_m[n] = (n < 5) ? 2'b01 : ((n == 5) ? 2'b10 : 2'b00);
         access_reg(1'b1, `DSP_OFS_OUTSEL, n, 32'(dest_m[n]), 1'b1, rd);
      end
      repeat (TREE_LAT + 1) @(negedge clk_i);
      expect_hex("dac_a_o", expected_dac(0), dac_a_o);
      expect_hex("dac_b_o", expected_dac(1), dac_b_o);
      access_reg(1'b0, `DSP_OFS_SAT, 0, '0, 1'b1, rd);
      expect_hex("sys_rdata_o", 32'h1, rd);
      // dac b now sums -40000
      for (int n = 6; n < `DSP_DIRECTS; n++) begin
         dest_m[n] = 2'b10;
         access_reg(1'b1, `DSP_OFS_OUTSEL, n, 32'(dest_m[n]), 1'b1, rd);
      end
      repeat (TREE_LAT + 1) @(negedge clk_i);
      expect_hex("dac_a_o", expected_dac(0), dac_a_o);
      expect_hex("dac_b_o", expected_dac(1), dac_b_o);
      access_reg(1'b0, `DSP_OFS_SAT, 0, '0, 1'b1, rd);
      expect_hex("sys_rdata_o", 32'h3, rd);
      randomize_directs();
      repeat (TREE_LAT + 1) @(negedge clk_i);
      expect_hex("dac_a_o", expected_dac(0), dac_a_o);
      expect_hex("dac_b_o", expected_dac(1), dac_b_o);
      access_reg(1'b0, `DSP_OFS_SAT, 0, '0, 1'b1, rd);
      expect_hex("sys_rdata_o", 32'h0, rd);

      // bus protocol, unmapped offsets, probe readback and sync
      access_reg(1'b0, 16'h0014, 0, '0, 1'b0, rd);
      access_reg(1'b1, 16'h0020, 3, 32'hFFFF, 1'b0, rd);
      for (int n = 0; n < `DSP_SOURCES; n++) begin
         access_reg(1'b0, `DSP_OFS_PROBE, n, '0, 1'b1, rd);
         expect_hex("sys_rdata_o", {18'd0, source_value(n)}, rd);
      end
      code = int'(rand_word() & 32'hFF);
      access_reg(1'b1, `DSP_OFS_SYNC, 5, 32'(code), 1'b1, rd);   // index ignored
      expect_hex("sync_o", 32'(code), 32'(sync_o));
      access_reg(1'b0, `DSP_OFS_SYNC, 0, '0, 1'b1, rd);
      expect_hex("sys_rdata_o", 32'(code), rd);

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/dsp_pkg.sv
hw/dsp_route_regs.sv
hw/dsp_signal_router.sv
hw/dsp_sum_tree.sv
hw/dsp_dac_saturate.sv
hw/dsp_hub.sv
bench/dsp_hub_clkgen.sv
bench/dsp_hub_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the routing hub testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   -f verilog.f --top-module dsp_hub_tb -o dsp_hub_sim
./obj_dir/dsp_hub_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
